// ==== draw_config.svh ====
`ifndef DRAW_CONFIG_SVH
`define DRAW_CONFIG_SVH

// Screen geometry in pixels.
`define SCREEN_W      480
`define SCREEN_H      800
`define PIXEL_COUNT   (`SCREEN_W * `SCREEN_H)  // 384000 pixels.

// SDRAM write port widths.
`define ADDR_W        24    // Bank, row and column.
`define PIXEL_W       16    // RGB565.

// RGB565 colours.
`define COLOR_BLACK   16'h0000
`define COLOR_GREEN   16'h07E0
`define COLOR_YELLOW  16'hFFE0

// Digit glyphs, stored column by column.
`define GLYPH_COLS    12
`define GLYPH_ROWS    24
`define GLYPH_W       (`GLYPH_COLS * `GLYPH_ROWS)  // 288 bits.
`define DIGITS        8     // Nibbles in a 32-bit counter.

// Top-right pixel of each counter.
`define PHOTON_BASE   326580  // (180,680).
`define ACCUM_BASE    326606  // (206,680).

`endif

// ==== draw_pkg.sv ====
`include "draw_config.svh"

package draw_pkg;

  // Drawing commands.
  typedef enum logic [1:0] {
    OP_CLEAR,   // Whole screen black.
    OP_FRAME,   // Border and centre lines.
    OP_PHOTON,  // Photon counter digits.
    OP_ACCUM    // Accumulated counter digits.
  } draw_op_t;

  typedef enum logic [1:0] {
    F_IDLE,
    F_LOAD,   // Pick up run parameters.
    F_WRITE,  // Req held until wr_done.
    F_GAP     // Req low for a cycle.
  } fill_state_t;

  typedef enum logic [1:0] {
    G_IDLE,
    G_FETCH,  // Font ROM latency.
    G_WRITE,  // Req held until wr_done.
    G_GAP     // Req low for a cycle.
  } glyph_state_t;

  // One pixel write towards SDRAM.
  typedef struct packed {
    logic [`ADDR_W-1:0]  addr;
    logic [`PIXEL_W-1:0] data;
    logic                req;
  } wr_bus_t;

  // Straight run of pixels.
  typedef struct packed {
    logic [`ADDR_W-1:0]  first;
    logic [8:0]          step;   // 1 across, 480 down.
    logic [`ADDR_W-1:0]  last;
    logic [`PIXEL_W-1:0] color;
  } segment_t;

  localparam int unsigned FRAME_SEG_N = 5;

  // Addresses sit one pixel before the screen coordinate.
  localparam segment_t FRAME_SEGS [FRAME_SEG_N] = '{
    '{24'd4809,   9'd1,   24'd5269,   `COLOR_GREEN},   // Top edge.
    '{24'd379209, 9'd1,   24'd379669, `COLOR_GREEN},   // Bottom edge.
    '{24'd4809,   9'd480, 24'd379209, `COLOR_GREEN},   // Left edge.
    '{24'd5269,   9'd480, 24'd379669, `COLOR_GREEN},   // Right edge.
    '{24'd5039,   9'd480, 24'd379439, `COLOR_YELLOW}   // Centre line.
  };

endpackage

// ==== font_rom.sv ====
`include "draw_config.svh"

module font_rom (
  input  logic                clk,
  input  logic [3:0]          index,
  output logic [`GLYPH_W-1:0] glyph
);

  // Digits 0..9, then six blank entries.
  logic [`GLYPH_W-1:0] mem [16];

  initial begin
    $readmemh("font_digits.mem", mem);
  end

  always_ff @(posedge clk) begin
    glyph <= mem[index];  // One cycle read.
  end

endmodule

// ==== fill_engine.sv ====
`include "draw_config.svh"

module fill_engine
  import draw_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    start,
  input  logic    frame,    // 0 clear, 1 frame.
  input  logic    wr_done,
  output wr_bus_t wr,
  output logic    busy,
  output logic    done
);

  fill_state_t         state;
  logic                frame_q;   // Job kind.
  logic [2:0]          seg_idx;   // Current frame segment.
  segment_t            seg;
  logic [`ADDR_W-1:0]  addr_q;
  logic [`ADDR_W-1:0]  last_q;
  logic [8:0]          step_q;
  logic [`PIXEL_W-1:0] color_q;
  logic                run_end;
  logic                job_end;

  assign seg     = FRAME_SEGS[seg_idx];
  assign run_end = (addr_q == last_q);  // Last pixel of this run.
  assign job_end = !frame_q || (seg_idx == 3'(FRAME_SEG_N - 1));

  ////////////////////////////////////////////////////////////
  // Run sequencing.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= F_IDLE;
      frame_q <= 1'b0;
      seg_idx <= '0;
      done    <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        F_IDLE: begin
          if (start) begin
            frame_q <= frame;
            seg_idx <= '0;
            state   <= F_LOAD;
          end
        end
        F_LOAD:  state <= F_WRITE;
        F_WRITE: begin
          if (wr_done) begin
            if (!run_end) begin
              state <= F_GAP;
            end else if (job_end) begin
              state <= F_IDLE;
              done  <= 1'b1;        // Cycle after the last wr_done.
            end else begin
              seg_idx <= seg_idx + 3'd1;  // Next frame line.
              state   <= F_LOAD;
            end
          end
        end
        F_GAP:   state <= F_WRITE;
        default: state <= F_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Address and colour of the current pixel.
  always_ff @(posedge clk) begin
    if (state == F_LOAD) begin
      if (frame_q) begin
        addr_q  <= seg.first;
        step_q  <= seg.step;
        last_q  <= seg.last;
        color_q <= seg.color;
      end else begin
        // Clear is a single black run over the screen.
        addr_q  <= '0;
        step_q  <= 9'd1;
        last_q  <= `ADDR_W'(`PIXEL_COUNT - 1);
        color_q <= `COLOR_BLACK;
      end
    end else if (state == F_WRITE && wr_done && !run_end) begin
      addr_q <= addr_q + `ADDR_W'(step_q);
    end
  end

  assign wr   = '{addr: addr_q, data: color_q, req: (state == F_WRITE)};
  assign busy = (state != F_IDLE);

endmodule

// ==== glyph_engine.sv ====
`include "draw_config.svh"

module glyph_engine
  import draw_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        start,
  input  logic        accum,    // Second counter position.
  input  logic [31:0] value,
  input  logic        wr_done,
  output wr_bus_t     wr,
  output logic        busy,
  output logic        done
);

  glyph_state_t        state;
  logic [31:0]         value_q;   // Shifts left a nibble per digit.
  logic [`ADDR_W-1:0]  addr_q;
  logic [2:0]          digit_q;
  logic [3:0]          col_q;
  logic [4:0]          row_q;
  logic [`GLYPH_W-1:0] glyph;
  logic [8:0]          bit_idx;
  logic                row_end;
  logic                col_end;
  logic                digit_end;

  // Most significant nibble selects the glyph.
  font_rom i_font_rom (
    .clk   (clk),
    .index (value_q[31:28]),
    .glyph (glyph)
  );

  assign bit_idx   = 9'(col_q) * 9'(`GLYPH_ROWS) + 9'(row_q);  // c*24+k.
  assign row_end   = (row_q == 5'(`GLYPH_ROWS - 1));
  assign col_end   = (col_q == 4'(`GLYPH_COLS - 1));
  assign digit_end = (digit_q == 3'(`DIGITS - 1));

  ////////////////////////////////////////////////////////////
  // Digit, column and row stepping.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= G_IDLE;
      digit_q <= '0;
      col_q   <= '0;
      row_q   <= '0;
      done    <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        G_IDLE: begin
          if (start) begin
            digit_q <= '0;
            col_q   <= '0;
            row_q   <= '0;
            state   <= G_FETCH;
          end
        end
        G_FETCH: state <= G_WRITE;   // Glyph valid next cycle.
        G_WRITE: begin
          if (wr_done) begin
            if (!row_end) begin
              row_q <= row_q + 5'd1;
              state <= G_GAP;
            end else if (!col_end) begin
              row_q <= '0;
              col_q <= col_q + 4'd1;
              state <= G_GAP;
            end else if (!digit_end) begin
              row_q   <= '0;
              col_q   <= '0;
              digit_q <= digit_q + 3'd1;
              state   <= G_FETCH;    // New nibble, new glyph.
            end else begin
              state <= G_IDLE;
              done  <= 1'b1;
            end
          end
        end
        G_GAP:   state <= G_WRITE;
        default: state <= G_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Value and pixel address.
  always_ff @(posedge clk) begin
    if (state == G_IDLE && start) begin
      value_q <= value;
      addr_q  <= (accum ? `ADDR_W'(`ACCUM_BASE) : `ADDR_W'(`PHOTON_BASE)) - 1'b1;
    end else if (state == G_WRITE && wr_done) begin
      if (row_end) begin
        // Back to row 0, one column down: +504 less the row step.
        addr_q <= addr_q + `ADDR_W'(`SCREEN_W + `GLYPH_ROWS - 1);
        if (col_end) begin
          value_q <= value_q << 4;
        end
      end else begin
        addr_q <= addr_q - 1'b1;  // Next row.
      end
    end
  end

  assign wr.addr = addr_q;
  assign wr.data = glyph[bit_idx] ? `COLOR_GREEN : `COLOR_BLACK;
  assign wr.req  = (state == G_WRITE);
  assign busy    = (state != G_IDLE);

endmodule

// ==== wr_arbiter.sv ====
module wr_arbiter
  import draw_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  wr_bus_t fill_wr,
  input  wr_bus_t glyph_wr,
  input  logic    sdram_wr_done,
  output wr_bus_t sdram_wr,
  output logic    fill_wr_done,
  output logic    glyph_wr_done
);

  logic granted;   // Port owned until done.
  logic sel;       // 0 fill, 1 glyph.
  logic prio;      // Winner on a tie.

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      granted <= 1'b0;
      sel     <= 1'b0;
      prio    <= 1'b0;
    end else if (!granted) begin
      if (fill_wr.req || glyph_wr.req) begin
        granted <= 1'b1;
        // Tie goes to prio, else to whoever asks.
        sel <= (fill_wr.req && glyph_wr.req) ? prio : glyph_wr.req;
      end
    end else if (sdram_wr_done) begin
      granted <= 1'b0;
      prio    <= ~sel;   // Other engine next time.
    end
  end

  ////////////////////////////////////////////////////////////
  // Granted bus out, done back to its owner only.
  always_comb begin
    sdram_wr     = sel ? glyph_wr : fill_wr;
    sdram_wr.req = granted;  // Owner holds req until done.
  end

  assign fill_wr_done  = sdram_wr_done & granted & ~sel;
  assign glyph_wr_done = sdram_wr_done & granted & sel;

endmodule

// ==== draw_core.sv ====
module draw_core
  import draw_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        cmd_valid,
  input  draw_op_t    cmd_op,
  input  logic [31:0] cmd_data,
  input  logic        sdram_wr_done,
  output wr_bus_t     sdram_wr,
  output logic        fill_busy,
  output logic        glyph_busy,
  output logic        draw_done,
  output draw_op_t    done_op
);

  wr_bus_t  fill_wr;
  wr_bus_t  glyph_wr;
  logic     fill_wr_done;
  logic     glyph_wr_done;
  logic     fill_start;
  logic     glyph_start;
  logic     fill_done;
  logic     glyph_done;
  draw_op_t fill_op;     // Job in the fill engine.
  draw_op_t glyph_op;    // Job in the glyph engine.
  draw_op_t pend_op;
  logic     glyph_pend;  // Glyph done deferred by a collision.

  // Command decode. Engines drop strobes while busy.
  assign fill_start  = cmd_valid && (cmd_op == OP_CLEAR || cmd_op == OP_FRAME);
  assign glyph_start = cmd_valid && (cmd_op == OP_PHOTON || cmd_op == OP_ACCUM);

  fill_engine i_fill_engine (
    .clk     (clk),
    .rst_n   (rst_n),
    .start   (fill_start),
    .frame   (cmd_op == OP_FRAME),
    .wr_done (fill_wr_done),
    .wr      (fill_wr),
    .busy    (fill_busy),
    .done    (fill_done)
  );

  glyph_engine i_glyph_engine (
    .clk     (clk),
    .rst_n   (rst_n),
    .start   (glyph_start),
    .accum   (cmd_op == OP_ACCUM),
    .value   (cmd_data),
    .wr_done (glyph_wr_done),
    .wr      (glyph_wr),
    .busy    (glyph_busy),
    .done    (glyph_done)
  );

  wr_arbiter i_wr_arbiter (
    .clk           (clk),
    .rst_n         (rst_n),
    .fill_wr       (fill_wr),
    .glyph_wr      (glyph_wr),
    .sdram_wr_done (sdram_wr_done),
    .sdram_wr      (sdram_wr),
    .fill_wr_done  (fill_wr_done),
    .glyph_wr_done (glyph_wr_done)
  );

  ////////////////////////////////////////////////////////////
  // Op tracking and done merge.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fill_op    <= OP_CLEAR;
      glyph_op   <= OP_PHOTON;
      pend_op    <= OP_PHOTON;
      glyph_pend <= 1'b0;
    end else begin
      if (fill_start && !fill_busy) fill_op <= cmd_op;     // Accepted only.
      if (glyph_start && !glyph_busy) glyph_op <= cmd_op;
      glyph_pend <= fill_done && glyph_done;  // Fill goes first.
      if (fill_done && glyph_done) pend_op <= glyph_op;
    end
  end

  assign draw_done = fill_done | glyph_done | glyph_pend;
  assign done_op   = fill_done ? fill_op : (glyph_pend ? pend_op : glyph_op);

endmodule

// ==== tb_clk_gen.sv ====
module tb_clk_gen (
  output logic clk,
  output logic rst_n
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period.
  end

  // Reset held for 8 rising edges.
  initial begin
    rst_n = 1'b0;
    repeat (8) @(posedge clk);
    #1 rst_n = 1'b1;
  end

endmodule

// ==== tb_draw_core.sv ====
`include "draw_config.svh"

module tb_draw_core
  import draw_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  typedef enum logic [1:0] {
    M_SINGLE,  // One command.
    M_CONC,    // Frame, counter one cycle later.
    M_REPEAT   // Counter strobed again while busy.
  } mode_t;

  typedef struct packed {
    draw_op_t    op;
    logic [31:0] data;
    mode_t       mode;
    logic [31:0] count;  // Writes of this op.
  } step_t;

  localparam int FRAME_WRITES = 3265;
  localparam int STEP_N = 7;

  localparam step_t STEPS [STEP_N] = '{
    '{OP_CLEAR,  32'h0000_0000, M_SINGLE, 32'd384000},
    '{OP_FRAME,  32'h0000_0000, M_SINGLE, 32'd3265},
    '{OP_PHOTON, 32'h0123_4567, M_SINGLE, 32'd2304},
    '{OP_ACCUM,  32'h89AB_CDEF, M_SINGLE, 32'd2304},  // Blank glyphs above 9.
    '{OP_PHOTON, 32'hFEDC_BA98, M_CONC,   32'd2304},
    '{OP_ACCUM,  32'h5A0F_3C96, M_CONC,   32'd2304},
    '{OP_PHOTON, 32'h7777_0A0A, M_REPEAT, 32'd2304}
  };

  // Frame lines in draw order, later lines overwrite.
  localparam int SEG_FIRST [5] = '{4809, 379209, 4809, 5269, 5039};
  localparam int SEG_STEP  [5] = '{1, 1, 480, 480, 480};
  localparam int SEG_LAST  [5] = '{5269, 379669, 379209, 379669, 379439};
  localparam logic [`PIXEL_W-1:0] SEG_COLOR [5] = '{
    `COLOR_GREEN, `COLOR_GREEN, `COLOR_GREEN, `COLOR_GREEN, `COLOR_YELLOW
  };

  // Screen box holding both counters.
  localparam int AREA_X0 = (`PHOTON_BASE % `SCREEN_W) - `GLYPH_ROWS;
  localparam int AREA_X1 = (`ACCUM_BASE % `SCREEN_W) - 1;
  localparam int AREA_Y0 = `PHOTON_BASE / `SCREEN_W;
  localparam int AREA_Y1 = AREA_Y0 + `DIGITS * `GLYPH_COLS - 1;

  logic        clk;
  logic        rst_n;
  logic        cmd_valid;
  draw_op_t    cmd_op;
  logic [31:0] cmd_data;
  logic        sdram_wr_done;
  wr_bus_t     sdram_wr;
  logic        fill_busy;
  logic        glyph_busy;
  logic        draw_done;
  draw_op_t    done_op;

  logic [`GLYPH_W-1:0] font [16];
  logic [`PIXEL_W-1:0] pix_seen [int];  // Last write per address.
  logic [`PIXEL_W-1:0] pix_exp [int];
  draw_op_t            done_q [$];
  int                  total_writes;
  int                  area_writes;
  logic [7:0]          lfsr_state = 8'd18;

  tb_clk_gen i_tb_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  draw_core i_draw_core (
    .clk           (clk),
    .rst_n         (rst_n),
    .cmd_valid     (cmd_valid),
    .cmd_op        (cmd_op),
    .cmd_data      (cmd_data),
    .sdram_wr_done (sdram_wr_done),
    .sdram_wr      (sdram_wr),
    .fill_busy     (fill_busy),
    .glyph_busy    (glyph_busy),
    .draw_done     (draw_done),
    .done_op       (done_op)
  );

  ////////////////////////////////////////////////////////////
  // Checks.
  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_pixel(input logic [`PIXEL_W-1:0] got, input logic [`PIXEL_W-1:0] exp,
                             input int addr);
    if (got !== exp) begin
      stop_run($sformatf("ERR %0t pixel[%0d] exp=%h got=%h", $time, addr, exp, got));
    end
  endtask

  task automatic check_count(input int got, input int exp, input string name);
    if (got != exp) begin
      stop_run($sformatf("ERR %0t %s exp=%0d got=%0d", $time, name, exp, got));
    end
  endtask

  task automatic check_op(input draw_op_t got, input draw_op_t exp, input string name);
    if (got !== exp) begin
      stop_run($sformatf("ERR %0t %s exp=%s got=%s", $time, name, exp.name(), got.name()));
    end
  endtask

  task automatic check_level(input logic got, input logic exp, input string name);
    if (got !== exp) begin
      stop_run($sformatf("ERR %0t %s exp=%b got=%b", $time, name, exp, got));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // SDRAM model.
  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int b = 0; b < n; b++) begin
      // Taps 8, 6, 5, 4.
      lfsr_state = {lfsr_state[6:0], lfsr_state[7] ^ lfsr_state[5] ^ lfsr_state[4] ^ lfsr_state[3]};
      v = (v << 1) | int'(lfsr_state[0]);
    end
    return v;
  endfunction

  function automatic logic in_counter_area(input logic [`ADDR_W-1:0] addr);
    int x;
    int y;
    x = int'(addr) % `SCREEN_W;
    y = int'(addr) / `SCREEN_W;
    return (x >= AREA_X0 && x <= AREA_X1 && y >= AREA_Y0 && y <= AREA_Y1);
  endfunction

  task automatic record_write(input wr_bus_t w);
    pix_seen[int'(w.addr)] = w.data;
    total_writes++;
    if (in_counter_area(w.addr)) begin
      area_writes++;
    end
  endtask

  initial begin : sdram_model
    int delay;
    sdram_wr_done = 1'b0;
    forever begin
      @(posedge clk);
      if (rst_n && sdram_wr.req) begin
        delay = 1 + rand_bits(2);  // 1 to 4 cycles.
        repeat (delay - 1) @(posedge clk);
        #1;
        sdram_wr_done = 1'b1;
        record_write(sdram_wr);
        @(posedge clk);
        #1;
        sdram_wr_done = 1'b0;
      end
    end
  end

  always @(negedge clk) begin
    if (rst_n && draw_done) begin
      done_q.push_back(done_op);  // One entry per pulse.
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus and waits.
  task automatic issue(input draw_op_t op, input logic [31:0] data);
    cmd_valid = 1'b1;
    cmd_op    = op;
    cmd_data  = data;
    @(posedge clk);
    #1;
    cmd_valid = 1'b0;
  endtask

  task automatic wait_reset(input int limit);
    int cyc;
    cyc = 0;
    while (rst_n !== 1'b1) begin
      @(posedge clk);
      cyc++;
      if (cyc > limit) begin
        stop_run("Reset was never released");
      end
    end
  endtask

  task automatic wait_glyph_busy(input int limit);
    int cyc;
    cyc = 0;
    while (!glyph_busy) begin
      @(posedge clk);
      #1;
      cyc++;
      if (cyc > limit) begin
        stop_run("Glyph engine never became busy");
      end
    end
  endtask

  task automatic wait_dones(input int n, input int limit);
    int cyc;
    cyc = 0;
    while (done_q.size() < n) begin
      @(posedge clk);
      cyc++;
      if (cyc > limit) begin
        stop_run("Timed out waiting for draw_done");
      end
    end
  endtask

  task automatic wait_idle(input int limit);
    int cyc;
    cyc = 0;
    while (fill_busy || glyph_busy) begin
      @(posedge clk);
      cyc++;
      if (cyc > limit) begin
        stop_run("Engines still busy after their done pulses");
      end
    end
  endtask

  task automatic check_idle(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      check_level(sdram_wr.req, 1'b0, "sdram_wr.req");
      check_level(draw_done, 1'b0, "draw_done");
      check_level(fill_busy, 1'b0, "fill_busy");
      check_level(glyph_busy, 1'b0, "glyph_busy");
    end
    check_count(total_writes, 0, "writes before any command");
  endtask

  ////////////////////////////////////////////////////////////
  // Expected pixels from the drawing rules.
  task automatic expect_clear();
    for (int a = 0; a < `PIXEL_COUNT; a++) begin
      pix_exp[a] = `COLOR_BLACK;
    end
  endtask

  task automatic expect_frame();
    for (int s = 0; s < 5; s++) begin
      for (int a = SEG_FIRST[s]; a <= SEG_LAST[s]; a += SEG_STEP[s]) begin
        pix_exp[a] = SEG_COLOR[s];
      end
    end
  endtask

  task automatic expect_counter(input draw_op_t op, input logic [31:0] value);
    int         base;
    int         addr;
    logic [3:0] nib;
    base = (op == OP_ACCUM) ? `ACCUM_BASE : `PHOTON_BASE;
    for (int d = 0; d < `DIGITS; d++) begin
      nib = value[31 - 4 * d -: 4];  // Top nibble first.
      for (int c = 0; c < `GLYPH_COLS; c++) begin
        for (int k = 0; k < `GLYPH_ROWS; k++) begin
          addr = base - 1 + (d * `GLYPH_COLS + c) * `SCREEN_W - k;
          pix_exp[addr] = font[nib][c * `GLYPH_ROWS + k] ? `COLOR_GREEN : `COLOR_BLACK;
        end
      end
    end
  endtask

  task automatic compare_pixels();
    check_count(pix_seen.num(), pix_exp.num(), "addresses written");
    foreach (pix_exp[a]) begin
      if (!pix_seen.exists(a)) begin
        stop_run($sformatf("No write seen at address %0d", a));
      end
      check_pixel(pix_seen[a], pix_exp[a], a);
    end
  endtask

  task automatic run_step(input step_t s);
    int n_done;
    int limit;
    pix_seen.delete();
    pix_exp.delete();
    done_q.delete();
    total_writes = 0;
    area_writes  = 0;
    n_done = (s.mode == M_CONC) ? 2 : 1;
    limit  = int'(s.count) * 8 + FRAME_WRITES * 8 + 1000;
    if (s.mode == M_CONC) begin
      issue(OP_FRAME, 32'h0);
    end
    issue(s.op, s.data);
    if (s.mode == M_REPEAT) begin
      wait_glyph_busy(16);
      issue(s.op, ~s.data);  // Must be dropped.
    end
    wait_dones(n_done, limit);
    wait_idle(64);
    repeat (8) @(posedge clk);  // Room for a stray done.
    #1;
    if (s.mode == M_CONC) begin
      expect_frame();
    end
    case (s.op)
      OP_CLEAR: expect_clear();
      OP_FRAME: expect_frame();
      default:  expect_counter(s.op, s.data);
    endcase
    check_count(total_writes, int'(s.count) + ((s.mode == M_CONC) ? FRAME_WRITES : 0),
                "sdram writes");
    if (s.mode == M_CONC) begin
      check_count(area_writes, int'(s.count), "counter area writes");
    end
    compare_pixels();
    check_count(done_q.size(), n_done, "draw_done pulses");
    // Finish order of a concurrent pair is not fixed.
    if (n_done == 2 && done_q[0] == OP_FRAME) begin
      check_op(done_q[1], s.op, "done_op");
    end else begin
      check_op(done_q[0], s.op, "done_op");
      if (n_done == 2) begin
        check_op(done_q[1], OP_FRAME, "done_op");
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence.
  initial begin : main
    cmd_valid = 1'b0;
    cmd_op    = OP_CLEAR;
    cmd_data  = '0;
    $readmemh("font_digits.mem", font);
    wait_reset(64);
    check_idle(16);
    @(posedge clk);
    #1;
    for (int i = 0; i < STEP_N; i++) begin
      run_step(STEPS[i]);
    end
    $display("Test passed");
    $finish;
  end

endmodule

// ==== font_digits.mem ====
// One 12x24 glyph per line for digit values 0 to 15.
// Column 11 first, six hex digits per column, row 0 in the low bit.
0000000000003FFFFC3FFFFC30000C30000C30000C30000C3FFFFC3FFFFC000000000000
0000000000003FFFFC3FFFFC000000000000000000000000000000000000000000000000
000000000000301FFC301FFC30180C30180C30180C30180C3FF80C3FF80C000000000000
0000000000003FFFFC3FFFFC30180C30180C30180C30180C30180C30180C000000000000
0000000000003FFFFC3FFFFC001800001800001800001800001FFC001FFC000000000000
0000000000003FF80C3FF80C30180C30180C30180C30180C301FFC301FFC000000000000
0000000000003FF80C3FF80C30180C30180C30180C30180C3FFFFC3FFFFC000000000000
0000000000003FFFFC3FFFFC00000C00000C00000C00000C00000C00000C000000000000
0000000000003FFFFC3FFFFC30180C30180C30180C30180C3FFFFC3FFFFC000000000000
0000000000003FFFFC3FFFFC30180C30180C30180C30180C301FFC301FFC000000000000
000000000000000000000000000000000000000000000000000000000000000000000000
000000000000000000000000000000000000000000000000000000000000000000000000
000000000000000000000000000000000000000000000000000000000000000000000000
000000000000000000000000000000000000000000000000000000000000000000000000
000000000000000000000000000000000000000000000000000000000000000000000000
000000000000000000000000000000000000000000000000000000000000000000000000

// ==== list.f ====
+incdir+.
draw_pkg.sv
font_rom.sv
fill_engine.sv
glyph_engine.sv
wr_arbiter.sv
draw_core.sv
tb_clk_gen.sv
tb_draw_core.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = tb_draw_core
FILELIST = list.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run and check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o $(TOP)
	./$(BUILD)/$(TOP) | tee $(LOG)
	@grep -q "Test passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
